// ==== hdl/poker_pkg.sv ====
package poker_pkg;

    // every chip quantity on the table: balances, pot, bets
    localparam int chip_w = 7;

    typedef logic [chip_w-1:0] chip_t;

    // betting rounds of one hand
    typedef enum logic [1:0] {
        preflop,
        flop,
        turn,
        river
    } round_t;

    // table modes
    typedef enum logic [1:0] {
        playing,
        cashout,
        freeze
    } game_state_t;

    // player actions, one per strobe
    typedef enum logic [1:0] {
        act_fold,
        act_call,
        act_raise
    } action_t;

endpackage

// ==== hdl/table_if.sv ====
`timescale 1ns/1ps

interface table_if;
    logic                act_valid;
    poker_pkg::action_t  act;
    logic                new_table;
    poker_pkg::round_t   round;

    // action strobes go one way, the current round comes back
    modport ctrl (
        output act_valid,
        output act,
        output new_table,
        input  round
    );

    modport engine (
        input  act_valid,
        input  act,
        input  new_table,
        output round
    );
endinterface

// ==== hdl/game_control.sv ====
`timescale 1ns/1ps

module game_control (
    input  logic                   clk,
    input  logic                   reset_d,
    input  logic                   fold_btn,
    input  logic                   call_btn,
    input  logic                   raise_btn,
    input  logic                   cashout_sw,
    input  logic                   freeze_sw,
    output poker_pkg::game_state_t game_state,
    table_if.ctrl                  tif
);
    logic [2:0]             btn_now;
    logic [2:0]             btn_prev;
    logic [2:0]             btn_rise;
    poker_pkg::game_state_t saved_state;

    // bit 0 fold, bit 1 call, bit 2 raise
    assign btn_now  = {raise_btn, call_btn, fold_btn};
    assign btn_rise = btn_now & ~btn_prev;

    // fold wins over call, call over raise
    always_ff @(posedge clk) begin
        if (btn_rise[0]) begin
            tif.act <= poker_pkg::act_fold;
        end else if (btn_rise[1]) begin
            tif.act <= poker_pkg::act_call;
        end else begin
            tif.act <= poker_pkg::act_raise;
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            btn_prev      <= 3'b000;
            tif.act_valid <= 1'b0;
            tif.new_table <= 1'b0;
            game_state    <= poker_pkg::playing;
            saved_state   <= poker_pkg::playing;
        end else begin
            btn_prev      <= btn_now;
            tif.act_valid <= (game_state == poker_pkg::playing) && (btn_rise != 3'b000);
            tif.new_table <= 1'b0;
            case (game_state)
                poker_pkg::playing: begin
                    if (freeze_sw) begin
                        game_state  <= poker_pkg::freeze;
                        saved_state <= poker_pkg::playing;
                    end else if (cashout_sw && tif.round == poker_pkg::preflop) begin
                        game_state <= poker_pkg::cashout;
                    end
                end
                poker_pkg::cashout: begin
                    if (freeze_sw) begin
                        game_state  <= poker_pkg::freeze;
                        saved_state <= poker_pkg::cashout;
                    end else if (!cashout_sw) begin
                        // leaving cashout starts a fresh table
                        game_state    <= poker_pkg::playing;
                        tif.new_table <= 1'b1;
                    end
                end
                poker_pkg::freeze: begin
                    if (!freeze_sw) begin
                        game_state <= saved_state;
                    end
                end
                default: begin
                    game_state <= poker_pkg::playing;
                end
            endcase
        end
    end
endmodule

// ==== hdl/bet_engine.sv ====
`timescale 1ns/1ps

module bet_engine #(
    parameter int start_balance = 49,
    parameter int raise_step    = 5
) (
    input  logic             clk,
    input  logic             reset_d,
    input  logic             p1_wins,
    input  logic             tie,
    table_if.engine          tif,
    output poker_pkg::chip_t p1_balance,
    output poker_pkg::chip_t p2_balance,
    output poker_pkg::chip_t pot,
    output poker_pkg::chip_t cur_bet,
    output logic             cur_player
);
    poker_pkg::chip_t  p1_betted;
    poker_pkg::chip_t  p2_betted;
    logic [7:0]        hand_cnt;
    poker_pkg::round_t round_q;
    logic              start_player;

    poker_pkg::chip_t  my_bal;
    poker_pkg::chip_t  my_betted;
    poker_pkg::chip_t  owed;
    poker_pkg::chip_t  raise_cost;

    poker_pkg::chip_t  p1_n;
    poker_pkg::chip_t  p2_n;
    poker_pkg::chip_t  pot_n;
    poker_pkg::chip_t  bet_n;
    poker_pkg::chip_t  p1_bt_n;
    poker_pkg::chip_t  p2_bt_n;
    logic [7:0]        hand_n;
    poker_pkg::round_t round_n;
    logic              player_n;
    logic              hand_over;

    // even hand count means p1 opens
    assign start_player = hand_cnt[0];
    assign tif.round    = round_q;

    // figures for whoever is to act
    assign my_bal     = cur_player ? p2_balance : p1_balance;
    assign my_betted  = cur_player ? p2_betted : p1_betted;
    assign owed       = cur_bet - my_betted;
    assign raise_cost = owed + poker_pkg::chip_t'(raise_step);

    always_comb begin
        p1_n      = p1_balance;
        p2_n      = p2_balance;
        pot_n     = pot;
        bet_n     = cur_bet;
        p1_bt_n   = p1_betted;
        p2_bt_n   = p2_betted;
        hand_n    = hand_cnt;
        round_n   = round_q;
        player_n  = cur_player;
        hand_over = 1'b0;
        if (tif.new_table) begin
            p1_n     = poker_pkg::chip_t'(start_balance);
            p2_n     = poker_pkg::chip_t'(start_balance);
            pot_n    = '0;
            bet_n    = '0;
            p1_bt_n  = '0;
            p2_bt_n  = '0;
            hand_n   = '0;
            round_n  = poker_pkg::preflop;
            player_n = 1'b0;
        end else if (tif.act_valid) begin
            case (tif.act)
                poker_pkg::act_fold: begin
                    if (cur_player) begin
                        p1_n = p1_balance + pot;
                    end else begin
                        p2_n = p2_balance + pot;
                    end
                    hand_over = 1'b1;
                end
                poker_pkg::act_call: begin
                    if (cur_bet != '0 && my_bal < owed) begin
                        // short stack, call ignored
                    end else if (cur_bet != '0 || cur_player != start_player) begin
                        // owed is zero on a check
                        if (cur_player) begin
                            p2_n = p2_balance - owed;
                        end else begin
                            p1_n = p1_balance - owed;
                        end
                        pot_n = pot + owed;
                        if (round_q == poker_pkg::river) begin
                            // showdown; an odd chip on a split is lost
                            if (tie) begin
                                p1_n = p1_n + (pot_n >> 1);
                                p2_n = p2_n + (pot_n >> 1);
                            end else if (p1_wins) begin
                                p1_n = p1_n + pot_n;
                            end else begin
                                p2_n = p2_n + pot_n;
                            end
                            hand_over = 1'b1;
                        end else begin
                            round_n  = poker_pkg::round_t'(round_q + 2'd1);
                            bet_n    = '0;
                            p1_bt_n  = '0;
                            p2_bt_n  = '0;
                            player_n = start_player;
                        end
                    end else begin
                        player_n = ~cur_player;
                    end
                end
                poker_pkg::act_raise: begin
                    if (my_bal >= raise_cost) begin
                        if (cur_player) begin
                            p2_n    = p2_balance - raise_cost;
                            p2_bt_n = cur_bet + poker_pkg::chip_t'(raise_step);
                        end else begin
                            p1_n    = p1_balance - raise_cost;
                            p1_bt_n = cur_bet + poker_pkg::chip_t'(raise_step);
                        end
                        pot_n = pot + raise_cost;
                        bet_n = cur_bet + poker_pkg::chip_t'(raise_step);
                    end
                    // turn passes even when the raise is refused
                    player_n = ~cur_player;
                end
                default: begin
                end
            endcase
            if (hand_over) begin
                pot_n    = '0;
                bet_n    = '0;
                p1_bt_n  = '0;
                p2_bt_n  = '0;
                round_n  = poker_pkg::preflop;
                hand_n   = hand_cnt + 8'd1;
                player_n = ~start_player;
            end
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            p1_balance <= poker_pkg::chip_t'(start_balance);
            p2_balance <= poker_pkg::chip_t'(start_balance);
            pot        <= '0;
            cur_bet    <= '0;
            p1_betted  <= '0;
            p2_betted  <= '0;
            hand_cnt   <= '0;
            round_q    <= poker_pkg::preflop;
            cur_player <= 1'b0;
        end else begin
            p1_balance <= p1_n;
            p2_balance <= p2_n;
            pot        <= pot_n;
            cur_bet    <= bet_n;
            p1_betted  <= p1_bt_n;
            p2_betted  <= p2_bt_n;
            hand_cnt   <= hand_n;
            round_q    <= round_n;
            cur_player <= player_n;
        end
    end
endmodule

// ==== hdl/poker_table.sv ====
`timescale 1ns/1ps

module poker_table #(
    parameter int start_balance = 49,
    parameter int raise_step    = 5
) (
    input  logic                   clk,
    input  logic                   reset_d,
    input  logic                   fold_btn,
    input  logic                   call_btn,
    input  logic                   raise_btn,
    input  logic                   cashout_sw,
    input  logic                   freeze_sw,
    input  logic                   p1_wins,
    input  logic                   tie,
    output poker_pkg::chip_t       p1_balance,
    output poker_pkg::chip_t       p2_balance,
    output poker_pkg::chip_t       pot,
    output poker_pkg::chip_t       cur_bet,
    output poker_pkg::round_t      round,
    output logic                   cur_player,
    output poker_pkg::game_state_t game_state
);
    table_if tif ();

    game_control u_ctrl (
        .clk        (clk),
        .reset_d    (reset_d),
        .fold_btn   (fold_btn),
        .call_btn   (call_btn),
        .raise_btn  (raise_btn),
        .cashout_sw (cashout_sw),
        .freeze_sw  (freeze_sw),
        .game_state (game_state),
        .tif        (tif.ctrl)
    );

    bet_engine #(
        .start_balance (start_balance),
        .raise_step    (raise_step)
    ) u_engine (
        .clk        (clk),
        .reset_d    (reset_d),
        .p1_wins    (p1_wins),
        .tie        (tie),
        .tif        (tif.engine),
        .p1_balance (p1_balance),
        .p2_balance (p2_balance),
        .pot        (pot),
        .cur_bet    (cur_bet),
        .cur_player (cur_player)
    );

    assign round = tif.round;
endmodule

// ==== bench/poker_table_chk.sv ====
`timescale 1ns/1ps

module poker_table_chk (
    input logic             clk,
    input logic             reset_d,
    input logic             act_valid,
    input logic             new_table,
    input poker_pkg::chip_t p1_balance,
    input poker_pkg::chip_t p2_balance,
    input poker_pkg::chip_t pot
);
    logic [8:0] chip_total;
    int         fail_cnt = 0;

    assign chip_total = 9'(p1_balance) + 9'(p2_balance) + 9'(pot);

    single_strobe: assert property (@(posedge clk) disable iff (reset_d)
        act_valid |=> !act_valid)
        else begin
            fail_cnt++;
            $error("act_valid held high for two cycles");
        end

    // chips only leave the table until a new table refills it
    no_chip_growth: assert property (@(posedge clk) disable iff (reset_d)
        !new_table |=> chip_total <= $past(chip_total))
        else begin
            fail_cnt++;
            $error("chip total grew without new_table");
        end

    idle_balances: assert property (@(posedge clk) disable iff (reset_d)
        (!act_valid && !new_table) |=> ($stable(p1_balance) && $stable(p2_balance)))
        else begin
            fail_cnt++;
            $error("balance changed with no strobe");
        end
endmodule

bind bet_engine poker_table_chk u_chk (
    .clk        (clk),
    .reset_d    (reset_d),
    .act_valid  (tif.act_valid),
    .new_table  (tif.new_table),
    .p1_balance (p1_balance),
    .p2_balance (p2_balance),
    .pot        (pot)
);

// ==== bench/poker_table_tb.sv ====
`timescale 1ns/1ps

module poker_table_tb;
    localparam int test_cycles    = 400;
    localparam int timeout_cycles = 5 * test_cycles;
    localparam int btn_fold       = 0;
    localparam int btn_call       = 1;
    localparam int btn_raise      = 2;

    logic                   clk;
    logic                   reset_d;
    logic                   fold_btn;
    logic                   call_btn;
    logic                   raise_btn;
    logic                   cashout_sw;
    logic                   freeze_sw;
    logic                   p1_wins;
    logic                   tie;
    poker_pkg::chip_t       p1_balance;
    poker_pkg::chip_t       p2_balance;
    poker_pkg::chip_t       pot;
    poker_pkg::chip_t       cur_bet;
    poker_pkg::round_t      round;
    logic                   cur_player;
    poker_pkg::game_state_t game_state;
    int                     err_cnt;
    int                     check_cnt;
    int                     test_cnt;
    int                     cycle_cnt;

    poker_table #(.start_balance(49), .raise_step(5)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic int total_errors();
        return err_cnt + UUT.u_engine.u_chk.fail_cnt;
    endfunction

    // outputs are read at the falling edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_d    <= 1'b1;
        cashout_sw <= 1'b0;
        freeze_sw  <= 1'b0;
        p1_wins    <= 1'b0;
        tie        <= 1'b0;
        repeat (2) @(posedge clk);
        reset_d <= 1'b0;
        @(negedge clk);
    endtask

    task automatic press(input int which);
        @(posedge clk);
        fold_btn  <= (which == btn_fold);
        call_btn  <= (which == btn_call);
        raise_btn <= (which == btn_raise);
        @(posedge clk);
        fold_btn  <= 1'b0;
        call_btn  <= 1'b0;
        raise_btn <= 1'b0;
        wait_cycles(3);
    endtask

    task automatic expect_table(input int p1, input int p2, input int pot_v, input int bet,
                                input int rnd, input int player);
        compare("p1_balance", p1_balance, p1);
        compare("p2_balance", p2_balance, p2);
        compare("pot", pot, pot_v);
        compare("cur_bet", cur_bet, bet);
        compare("round", round, rnd);
        compare("cur_player", cur_player, player);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("%-22s %s", name, (total_errors() == errs_before) ? "ok" : "failed");
    endtask

    task automatic reset_values();
        int e0;
        e0 = total_errors();
        apply_reset();
        expect_table(49, 49, 0, 0, 0, 0);
        compare("game_state", game_state, poker_pkg::playing);
        finish_test("reset values", e0);
    endtask

    task automatic raise_then_call();
        int e0;
        e0 = total_errors();
        apply_reset();
        press(btn_raise);
        expect_table(44, 49, 5, 5, 0, 1);
        press(btn_call);
        expect_table(44, 44, 10, 0, 1, 0);
        press(btn_raise);
        expect_table(39, 44, 15, 5, 1, 1);
        // re-raise costs the 5 owed plus the step
        press(btn_raise);
        expect_table(39, 34, 25, 10, 1, 0);
        finish_test("raise then call", e0);
    endtask

    task automatic fold_passes_pot();
        int e0;
        e0 = total_errors();
        apply_reset();
        press(btn_raise);
        press(btn_raise);
        press(btn_fold);
        expect_table(44, 54, 0, 0, 0, 1);
        // second hand opens with p2
        press(btn_raise);
        expect_table(44, 49, 5, 5, 0, 0);
        press(btn_fold);
        expect_table(44, 54, 0, 0, 0, 0);
        finish_test("fold", e0);
    endtask

    task automatic showdown_checkdown();
        int e0;
        e0 = total_errors();
        apply_reset();
        @(posedge clk);
        p1_wins <= 1'b1;
        tie     <= 1'b0;
        press(btn_raise);
        press(btn_call);
        expect_table(44, 44, 10, 0, 1, 0);
        for (int r = 2; r <= 3; r++) begin
            press(btn_call);
            press(btn_call);
            expect_table(44, 44, 10, 0, r, 0);
        end
        press(btn_call);
        press(btn_call);
        expect_table(54, 44, 0, 0, 0, 1);
        // split pot with p2 opening this hand
        @(posedge clk);
        tie <= 1'b1;
        press(btn_raise);
        press(btn_call);
        expect_table(49, 39, 10, 0, 1, 1);
        repeat (6) press(btn_call);
        expect_table(54, 44, 0, 0, 0, 0);
        finish_test("showdown", e0);
    endtask

    task automatic short_stack_call();
        int e0;
        e0 = total_errors();
        apply_reset();
        press(btn_raise);
        press(btn_raise);
        press(btn_fold);
        press(btn_raise);
        repeat (4) begin
            press(btn_raise);
            press(btn_raise);
        end
        expect_table(4, 9, 85, 45, 0, 0);
        // p1 owes 5 with only 4 left
        press(btn_call);
        expect_table(4, 9, 85, 45, 0, 0);
        finish_test("unaffordable call", e0);
    endtask

    task automatic mode_switches();
        int e0;
        e0 = total_errors();
        apply_reset();
        @(posedge clk);
        freeze_sw <= 1'b1;
        wait_cycles(2);
        compare("game_state", game_state, poker_pkg::freeze);
        press(btn_raise);
        expect_table(49, 49, 0, 0, 0, 0);
        @(posedge clk);
        freeze_sw <= 1'b0;
        wait_cycles(2);
        compare("game_state", game_state, poker_pkg::playing);
        press(btn_raise);
        press(btn_call);
        @(posedge clk);
        cashout_sw <= 1'b1;
        wait_cycles(2);
        compare("game_state", game_state, poker_pkg::playing);
        @(posedge clk);
        cashout_sw <= 1'b0;
        press(btn_fold);
        expect_table(44, 54, 0, 0, 0, 1);
        @(posedge clk);
        cashout_sw <= 1'b1;
        wait_cycles(2);
        compare("game_state", game_state, poker_pkg::cashout);
        @(posedge clk);
        cashout_sw <= 1'b0;
        wait_cycles(4);
        expect_table(49, 49, 0, 0, 0, 0);
        compare("game_state", game_state, poker_pkg::playing);
        finish_test("modes", e0);
    endtask

    initial begin
        reset_d    = 1'b1;
        fold_btn   = 1'b0;
        call_btn   = 1'b0;
        raise_btn  = 1'b0;
        cashout_sw = 1'b0;
        freeze_sw  = 1'b0;
        p1_wins    = 1'b0;
        tie        = 1'b0;
        err_cnt    = 0;
        check_cnt  = 0;
        test_cnt   = 0;
        reset_values();
        raise_then_call();
        fold_passes_pot();
        showdown_checkdown();
        short_stack_call();
        mode_switches();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

// ==== compile.f ====
hdl/poker_pkg.sv
hdl/table_if.sv
hdl/game_control.sv
hdl/bet_engine.sv
hdl/poker_table.sv
bench/poker_table_chk.sv
bench/poker_table_tb.sv
